// ==== bench/fir_checker.sv ====
`include "fir_macros.svh"

module fir_checker (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic                        awready,
    input  logic [`FIR_ADDR_WIDTH-1:0]  awaddr,
    input  logic                        wvalid,
    input  logic                        wready,
    input  logic [`FIR_DATA_WIDTH-1:0]  wdata,
    input  logic                        arvalid,
    input  logic                        arready,
    input  logic [`FIR_ADDR_WIDTH-1:0]  araddr,
    input  logic                        rvalid,
    input  logic                        rready,
    input  logic [`FIR_DATA_WIDTH-1:0]  rdata,
    input  logic                        ss_tvalid,
    input  logic                        ss_tready,
    input  fir_pkg::axis_beat_t         ss_beat,
    input  logic                        sm_tvalid,
    input  logic                        sm_tready,
    input  fir_pkg::axis_beat_t         sm_beat,
    output int                          error_count,
    output int                          check_count,
    output int                          result_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned TAP_END = `FIR_ADDR_TAP_BASE + 4 * `FIR_TAP_NUM;

    logic [`FIR_DATA_WIDTH-1:0]  tap_m [`FIR_TAP_NUM];
    logic [`FIR_DATA_WIDTH-1:0]  hist [`FIR_TAP_NUM];
    logic [`FIR_DATA_WIDTH-1:0]  len_m;
    logic [`FIR_DATA_WIDTH-1:0]  rd_exp;
    logic [`FIR_ADDR_WIDTH-1:0]  wr_addr;
    logic                        idle_m;
    logic                        done_m;
    logic                        rd_pending;
    int                          run_count;
    fir_pkg::axis_beat_t         exp_q [$];

    // Sum of tap[i] * x[n-i], truncated to the data width
    function automatic logic [`FIR_DATA_WIDTH-1:0] fir_ref(
        input logic [`FIR_DATA_WIDTH-1:0] taps [`FIR_TAP_NUM],
        input logic [`FIR_DATA_WIDTH-1:0] x [`FIR_TAP_NUM]
    );
        logic [`FIR_DATA_WIDTH-1:0] sum;
        sum = '0;
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            sum = sum + taps[i] * x[i];
        end
        return sum;
    endfunction

    function automatic bit is_tap(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        return (addr >= `FIR_ADDR_TAP_BASE) && (addr < TAP_END);
    endfunction

    function automatic logic [`FIR_DATA_WIDTH-1:0] model_read(
        input logic [`FIR_ADDR_WIDTH-1:0] addr
    );
        logic [`FIR_DATA_WIDTH-1:0] value;
        value = '0;
        if (addr == `FIR_ADDR_AP_CTRL) begin
            value[2:0] = {idle_m, done_m, 1'b0};
        end else if (addr == `FIR_ADDR_LENGTH) begin
            value = len_m;
        end else if (is_tap(addr)) begin
            value = tap_m[(int'(addr) - `FIR_ADDR_TAP_BASE) / 4];
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string text);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, text);
    endtask

    task automatic apply_write(input logic [`FIR_ADDR_WIDTH-1:0] addr,
                               input logic [`FIR_DATA_WIDTH-1:0] data);
        if (is_tap(addr)) begin
            tap_m[(int'(addr) - `FIR_ADDR_TAP_BASE) / 4] = data;
        end else if (addr == `FIR_ADDR_LENGTH) begin
            len_m = data;
        end else if ((addr == `FIR_ADDR_AP_CTRL) && data[0] && idle_m) begin
            // A new run starts from an empty history
            idle_m    = 1'b0;
            run_count = 0;
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                hist[i] = '0;
            end
            if (exp_q.size() != 0) report_error("samples left over from the previous run");
            exp_q.delete();
        end
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        result_count = 0;
    end

    always @(posedge axis_clk or negedge axis_rst_n) begin : compare_proc
        logic                ctrl_read;
        logic                last_seen;
        fir_pkg::axis_beat_t beat;
        if (!axis_rst_n) begin
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                tap_m[i] = '0;
                hist[i]  = '0;
            end
            len_m      = '0;
            idle_m     = 1'b1;
            done_m     = 1'b0;
            rd_pending = 1'b0;
            run_count  = 0;
            exp_q.delete();
        end else begin
            ctrl_read = 1'b0;
            last_seen = 1'b0;
            if (rvalid && rready) begin
                if (rd_pending) check_value("rdata", rdata, rd_exp);
                else report_error("read data returned with no read outstanding");
                rd_pending = 1'b0;
            end
            // Read value is taken before this edge's updates
            if (arvalid && arready) begin
                rd_exp     = model_read(araddr);
                rd_pending = 1'b1;
                ctrl_read  = (araddr == `FIR_ADDR_AP_CTRL);
            end
            if (awvalid && awready) wr_addr = awaddr;
            if (wvalid && wready) apply_write(wr_addr, wdata);
            if (ss_tvalid && ss_tready) begin
                for (int i = `FIR_TAP_NUM - 1; i > 0; i--) begin
                    hist[i] = hist[i-1];
                end
                hist[0]   = ss_beat.data;
                beat.data = fir_ref(tap_m, hist);
                beat.last = ss_beat.last;
                exp_q.push_back(beat);
            end
            if (sm_tvalid && sm_tready) begin
                result_count++;
                run_count++;
                if (exp_q.size() == 0) begin
                    report_error("result arrived with no sample outstanding");
                end else begin
                    beat = exp_q.pop_front();
                    check_value("sm_beat.data", sm_beat.data, beat.data);
                    check_value("sm_beat.last", sm_beat.last, beat.last);
                    // Status follows the expected end of the run
                    if (beat.last) begin
                        last_seen = 1'b1;
                        done_m    = 1'b1;
                        idle_m    = 1'b1;
                    end
                end
                if (sm_beat.last) begin
                    check_value("result_count", run_count, len_m);
                end
            end
            // Done set wins over the clear by a status read
            if (ctrl_read && !last_seen) done_m = 1'b0;
        end
    end

endmodule

// ==== bench/fir_tb.sv ====
`include "fir_macros.svh"

module fir_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SAMPLES    = 64;
    localparam int unsigned TIMEOUT_NS = 2 * SAMPLES * (3 * `FIR_TAP_NUM + 8) * 100 + 20000;

    logic                        axis_clk;
    logic                        axis_rst_n;
    logic                        awvalid;
    logic [`FIR_ADDR_WIDTH-1:0]  awaddr;
    logic                        awready;
    logic                        wvalid;
    logic [`FIR_DATA_WIDTH-1:0]  wdata;
    logic                        wready;
    logic                        arvalid;
    logic [`FIR_ADDR_WIDTH-1:0]  araddr;
    logic                        arready;
    logic                        rvalid;
    logic                        rready;
    logic [`FIR_DATA_WIDTH-1:0]  rdata;
    logic                        ss_tvalid;
    fir_pkg::axis_beat_t         ss_beat;
    logic                        ss_tready;
    logic                        sm_tready;
    logic                        sm_tvalid;
    fir_pkg::axis_beat_t         sm_beat;
    int                          error_count;
    int                          check_count;
    int                          result_count;
    int                          test_base;
    int                          seed = 70918;

    fir_top fir_top_inst (.*);

    fir_checker fir_checker_inst (.*);

    initial begin
        axis_clk = 1'b0;
        forever #50 axis_clk = ~axis_clk;
    end

    // Random back-pressure on the output stream
    initial begin
        sm_tready = 1'b0;
        forever begin
            @(negedge axis_clk);
            sm_tready = ($random(seed) & 1) != 0;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic lite_write(input logic [`FIR_ADDR_WIDTH-1:0] addr,
                              input logic [`FIR_DATA_WIDTH-1:0] data);
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(posedge axis_clk);
        while (!awready) @(posedge axis_clk);
        @(negedge axis_clk);
        awvalid = 1'b0;
        @(posedge axis_clk);
        while (!wready) @(posedge axis_clk);
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic lite_read(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(posedge axis_clk);
        while (!arready) @(posedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        @(posedge axis_clk);
        while (!rvalid) @(posedge axis_clk);
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic write_taps();
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            lite_write(`FIR_ADDR_TAP_BASE + 4 * i, $random(seed));
        end
    endtask

    task automatic stream_samples(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge axis_clk);
            ss_tvalid    = 1'b1;
            ss_beat.data = $random(seed);
            ss_beat.last = (i == count - 1);
            @(posedge axis_clk);
            while (!ss_tready) @(posedge axis_clk);
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_beat   = '0;
    endtask

    task automatic wait_results(input int target);
        while (result_count < target) @(negedge axis_clk);
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = error_count - test_base;
        $display("Test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "bad", errs);
        test_base = error_count;
    endtask

    initial begin
        test_base  = 0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_beat    = '0;
        repeat (3) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;

        lite_read(`FIR_ADDR_AP_CTRL);
        lite_read(`FIR_ADDR_LENGTH);
        finish_test(1, "reset values");

        write_taps();
        lite_write(`FIR_ADDR_LENGTH, SAMPLES);
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            lite_read(`FIR_ADDR_TAP_BASE + 4 * i);
        end
        lite_read(`FIR_ADDR_LENGTH);
        finish_test(2, "tap and length readback");

        lite_write(`FIR_ADDR_AP_CTRL, 32'h1);
        fork
            stream_samples(SAMPLES);
            begin
                repeat (200) @(negedge axis_clk);
                lite_read(`FIR_ADDR_AP_CTRL);
            end
        join
        wait_results(SAMPLES);
        finish_test(3, "first run");

        // Done and idle set, then done cleared by the read
        lite_read(`FIR_ADDR_AP_CTRL);
        lite_read(`FIR_ADDR_AP_CTRL);
        finish_test(4, "status bits");

        write_taps();
        lite_write(`FIR_ADDR_AP_CTRL, 32'h1);
        fork
            stream_samples(SAMPLES);
            begin
                repeat (300) @(negedge axis_clk);
                lite_read(`FIR_ADDR_TAP_BASE + 4 * 5);
            end
        join
        wait_results(2 * SAMPLES);
        lite_read(`FIR_ADDR_AP_CTRL);
        finish_test(5, "second run with new taps");

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== include/fir_macros.svh ====
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// Bus and datapath widths
`define FIR_ADDR_WIDTH 12
`define FIR_DATA_WIDTH 32

// Filter length and RAM depth
`define FIR_TAP_NUM 11
`define FIR_RAM_AWIDTH 4

// AXI-Lite register map
`define FIR_ADDR_AP_CTRL 12'h000
`define FIR_ADDR_LENGTH 12'h010
`define FIR_ADDR_TAP_BASE 12'h080

`endif

// ==== project.f ====
+incdir+include
verilog/fir_pkg.sv
verilog/fir_bram.sv
verilog/axil_regs.sv
verilog/tap_arbiter.sv
verilog/fir_engine.sv
verilog/fir_top.sv
bench/fir_checker.sv
bench/fir_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fir_tb \
    -f project.f --Mdir obj_dir -o fir_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/fir_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verilog/axil_regs.sv ====
`include "fir_macros.svh"

module axil_regs (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0]  wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  araddr,
    output logic                        arready,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`FIR_DATA_WIDTH-1:0]  rdata,
    output logic                        start,
    input  logic                        started,
    input  logic                        finished,
    output fir_pkg::ram_req_t           tap_req,
    output logic                        tap_valid,
    input  logic                        tap_gnt,
    input  logic                        tap_rvalid,
    input  logic [`FIR_DATA_WIDTH-1:0]  tap_rdata
);

    localparam int unsigned TAP_END = `FIR_ADDR_TAP_BASE + 4 * `FIR_TAP_NUM;

    fir_pkg::lite_state_e        state;
    logic [`FIR_ADDR_WIDTH-1:0]  addr_q;
    logic [`FIR_ADDR_WIDTH-1:0]  tap_off;
    logic [`FIR_DATA_WIDTH-1:0]  rdata_q;
    logic [`FIR_DATA_WIDTH-1:0]  reg_rdata;
    logic [`FIR_DATA_WIDTH-1:0]  data_length;
    logic                        rvalid_q;
    logic                        rd_issued;
    logic                        ap_start;
    logic                        ap_done;
    logic                        ap_idle;
    logic                        aw_hs;
    logic                        w_hs;
    logic                        ar_hs;
    logic                        q_tap;

    function automatic logic tap_hit(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        tap_hit = (addr >= `FIR_ADDR_TAP_BASE) && (addr < TAP_END[`FIR_ADDR_WIDTH-1:0]);
    endfunction

    assign q_tap   = tap_hit(addr_q);
    assign tap_off = addr_q - `FIR_ADDR_TAP_BASE;

    // Writes win over reads in the same cycle
    assign awready = (state == fir_pkg::LITE_IDLE) && awvalid;
    assign arready = (state == fir_pkg::LITE_IDLE) && arvalid && !awvalid;
    assign wready  = (state == fir_pkg::LITE_WDATA) && (q_tap ? tap_gnt : 1'b1);
    assign aw_hs   = awvalid && awready;
    assign ar_hs   = arvalid && arready;
    assign w_hs    = wvalid && wready;
    assign rvalid  = rvalid_q;
    assign rdata   = rdata_q;
    assign start   = ap_start;

    // Tap write waits for wvalid, tap read is requested once
    assign tap_valid = q_tap && (((state == fir_pkg::LITE_WDATA) && wvalid) ||
                                 ((state == fir_pkg::LITE_RDATA) && !rd_issued));

    always_comb begin
        tap_req.en    = tap_valid;
        tap_req.we    = (state == fir_pkg::LITE_WDATA);
        tap_req.addr  = tap_off[`FIR_RAM_AWIDTH+1:2];
        tap_req.wdata = wdata;
    end

    always_comb begin
        reg_rdata = '0;
        if (araddr == `FIR_ADDR_AP_CTRL) begin
            reg_rdata[2:0] = {ap_idle, ap_done, ap_start};
        end else if (araddr == `FIR_ADDR_LENGTH) begin
            reg_rdata = data_length;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= fir_pkg::LITE_IDLE;
            addr_q    <= '0;
            rvalid_q  <= 1'b0;
            rd_issued <= 1'b0;
        end else begin
            case (state)
                fir_pkg::LITE_IDLE: begin
                    if (aw_hs) begin
                        state  <= fir_pkg::LITE_WDATA;
                        addr_q <= awaddr;
                    end else if (ar_hs) begin
                        state    <= fir_pkg::LITE_RDATA;
                        addr_q   <= araddr;
                        rvalid_q <= !tap_hit(araddr);
                    end
                end
                fir_pkg::LITE_WDATA: begin
                    if (w_hs) begin
                        state <= fir_pkg::LITE_IDLE;
                    end
                end
                fir_pkg::LITE_RDATA: begin
                    if (tap_gnt) begin
                        rd_issued <= 1'b1;
                    end
                    if (tap_rvalid) begin
                        rvalid_q <= 1'b1;
                    end
                    if (rvalid_q && rready) begin
                        state     <= fir_pkg::LITE_IDLE;
                        rvalid_q  <= 1'b0;
                        rd_issued <= 1'b0;
                    end
                end
                default: begin
                    state <= fir_pkg::LITE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ar_hs) begin
            rdata_q <= reg_rdata;
        end else if (tap_rvalid) begin
            rdata_q <= tap_rdata;
        end
    end

    // ap_start only takes effect while idle
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start    <= 1'b0;
            ap_done     <= 1'b0;
            ap_idle     <= 1'b1;
            data_length <= '0;
        end else begin
            if (w_hs && (addr_q == `FIR_ADDR_LENGTH)) begin
                data_length <= wdata;
            end
            if (started) begin
                ap_start <= 1'b0;
                ap_idle  <= 1'b0;
            end else if (w_hs && (addr_q == `FIR_ADDR_AP_CTRL) && wdata[0] && ap_idle) begin
                ap_start <= 1'b1;
            end
            // Done set has priority over read clear
            if (finished) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (ar_hs && (araddr == `FIR_ADDR_AP_CTRL)) begin
                ap_done <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/fir_bram.sv ====
`include "fir_macros.svh"

module fir_bram (
    input  logic                        axis_clk,
    input  fir_pkg::ram_req_t           req,
    output logic [`FIR_DATA_WIDTH-1:0]  rdata
);

    localparam int unsigned DEPTH = 2 ** `FIR_RAM_AWIDTH;

    logic [`FIR_DATA_WIDTH-1:0] mem [DEPTH];

    // Read data holds until the next read
    always_ff @(posedge axis_clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

// ==== verilog/fir_engine.sv ====
`include "fir_macros.svh"

module fir_engine (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        start,
    output logic                        started,
    output logic                        finished,
    input  logic                        ss_tvalid,
    input  fir_pkg::axis_beat_t         ss_beat,
    output logic                        ss_tready,
    input  logic                        sm_tready,
    output logic                        sm_tvalid,
    output fir_pkg::axis_beat_t         sm_beat,
    output fir_pkg::ram_req_t           tap_req,
    output logic                        busy,
    input  logic [`FIR_DATA_WIDTH-1:0]  tap_rdata,
    output fir_pkg::ram_req_t           data_req,
    input  logic [`FIR_DATA_WIDTH-1:0]  data_rdata
);

    localparam int unsigned LAST_TAP = `FIR_TAP_NUM - 1;

    fir_pkg::engine_state_e      state;
    logic [`FIR_RAM_AWIDTH-1:0]  idx;
    logic [`FIR_DATA_WIDTH-1:0]  carry;
    logic [`FIR_DATA_WIDTH-1:0]  prod;
    logic [`FIR_DATA_WIDTH-1:0]  acc;
    logic                        last_q;
    logic                        last_tap;
    logic                        ss_hs;
    logic                        fetch_go;

    assign last_tap = (idx == LAST_TAP[`FIR_RAM_AWIDTH-1:0]);
    assign ss_tready = (state == fir_pkg::ENG_FETCH) && (idx == '0);
    assign ss_hs     = ss_tready && ss_tvalid;
    // Tap 0 only fetches together with a new sample
    assign fetch_go  = (state == fir_pkg::ENG_FETCH) && ((idx != '0) || ss_tvalid);

    assign started   = (state == fir_pkg::ENG_IDLE) && start;
    assign finished  = (state == fir_pkg::ENG_OUT) && sm_tready && last_q;
    assign sm_tvalid = (state == fir_pkg::ENG_OUT);
    assign busy      = fetch_go;

    always_comb begin
        sm_beat.data = acc;
        sm_beat.last = last_q;
    end

    always_comb begin
        tap_req.en    = fetch_go;
        tap_req.we    = 1'b0;
        tap_req.addr  = idx;
        tap_req.wdata = '0;
    end

    // History slot idx is read in FETCH and overwritten in MULT
    always_comb begin
        data_req.en    = 1'b0;
        data_req.we    = 1'b0;
        data_req.addr  = idx;
        data_req.wdata = '0;
        case (state)
            fir_pkg::ENG_CLEAR: begin
                data_req.en = 1'b1;
                data_req.we = 1'b1;
            end
            fir_pkg::ENG_FETCH: begin
                data_req.en = fetch_go;
            end
            fir_pkg::ENG_MULT: begin
                data_req.en    = 1'b1;
                data_req.we    = 1'b1;
                data_req.wdata = carry;
            end
            default: begin
                data_req.en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= fir_pkg::ENG_IDLE;
            idx    <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                fir_pkg::ENG_IDLE: begin
                    if (start) begin
                        state <= fir_pkg::ENG_CLEAR;
                        idx   <= '0;
                    end
                end
                fir_pkg::ENG_CLEAR: begin
                    if (last_tap) begin
                        state <= fir_pkg::ENG_FETCH;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                fir_pkg::ENG_FETCH: begin
                    if (fetch_go) begin
                        state <= fir_pkg::ENG_MULT;
                    end
                    if (ss_hs) begin
                        last_q <= ss_beat.last;
                    end
                end
                fir_pkg::ENG_MULT: begin
                    state <= fir_pkg::ENG_ACC;
                end
                fir_pkg::ENG_ACC: begin
                    if (last_tap) begin
                        state <= fir_pkg::ENG_OUT;
                    end else begin
                        state <= fir_pkg::ENG_FETCH;
                        idx   <= idx + 1'b1;
                    end
                end
                fir_pkg::ENG_OUT: begin
                    // Held here under back-pressure
                    if (sm_tready) begin
                        idx   <= '0;
                        state <= last_q ? fir_pkg::ENG_IDLE : fir_pkg::ENG_FETCH;
                    end
                end
                default: begin
                    state <= fir_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    // carry holds x[n-idx] on its way to history slot idx
    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            carry <= ss_beat.data;
            acc   <= '0;
        end
        if (state == fir_pkg::ENG_MULT) begin
            prod  <= tap_rdata * carry;
            carry <= data_rdata;
        end
        if (state == fir_pkg::ENG_ACC) begin
            acc <= acc + prod;
        end
    end

endmodule

// ==== verilog/fir_pkg.sv ====
`include "fir_macros.svh"

package fir_pkg;

    // AXI-Lite transaction phase
    typedef enum logic [1:0] {
        LITE_IDLE  = 2'd0,
        LITE_WDATA = 2'd1,
        LITE_RDATA = 2'd2
    } lite_state_e;

    // Filter engine sequence
    typedef enum logic [2:0] {
        ENG_IDLE  = 3'd0,
        ENG_CLEAR = 3'd1,
        ENG_FETCH = 3'd2,
        ENG_MULT  = 3'd3,
        ENG_ACC   = 3'd4,
        ENG_OUT   = 3'd5
    } engine_state_e;

    // One word access to a tap or data RAM
    typedef struct packed {
        logic                        en;
        logic                        we;
        logic [`FIR_RAM_AWIDTH-1:0]  addr;
        logic [`FIR_DATA_WIDTH-1:0]  wdata;
    } ram_req_t;

    // One AXI-Stream beat
    typedef struct packed {
        logic [`FIR_DATA_WIDTH-1:0]  data;
        logic                        last;
    } axis_beat_t;

endpackage

// ==== verilog/fir_top.sv ====
`include "fir_macros.svh"

module fir_top (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0]  wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  araddr,
    output logic                        arready,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`FIR_DATA_WIDTH-1:0]  rdata,
    input  logic                        ss_tvalid,
    input  fir_pkg::axis_beat_t         ss_beat,
    output logic                        ss_tready,
    input  logic                        sm_tready,
    output logic                        sm_tvalid,
    output fir_pkg::axis_beat_t         sm_beat
);

    logic                        start;
    logic                        started;
    logic                        finished;
    fir_pkg::ram_req_t           lite_tap_req;
    logic                        lite_tap_valid;
    logic                        lite_tap_gnt;
    logic                        lite_tap_rvalid;
    fir_pkg::ram_req_t           eng_tap_req;
    logic                        eng_busy;
    fir_pkg::ram_req_t           tap_ram_req;
    logic [`FIR_DATA_WIDTH-1:0]  tap_rdata;
    fir_pkg::ram_req_t           data_ram_req;
    logic [`FIR_DATA_WIDTH-1:0]  data_rdata;

    axil_regs axil_regs_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .start      (start),
        .started    (started),
        .finished   (finished),
        .tap_req    (lite_tap_req),
        .tap_valid  (lite_tap_valid),
        .tap_gnt    (lite_tap_gnt),
        .tap_rvalid (lite_tap_rvalid),
        .tap_rdata  (tap_rdata)
    );

    fir_engine fir_engine_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .started    (started),
        .finished   (finished),
        .ss_tvalid  (ss_tvalid),
        .ss_beat    (ss_beat),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_beat    (sm_beat),
        .tap_req    (eng_tap_req),
        .busy       (eng_busy),
        .tap_rdata  (tap_rdata),
        .data_req   (data_ram_req),
        .data_rdata (data_rdata)
    );

    tap_arbiter tap_arbiter_inst (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .lite_req    (lite_tap_req),
        .lite_valid  (lite_tap_valid),
        .lite_gnt    (lite_tap_gnt),
        .lite_rvalid (lite_tap_rvalid),
        .eng_req     (eng_tap_req),
        .eng_busy    (eng_busy),
        .ram_req     (tap_ram_req)
    );

    // Coefficients
    fir_bram tap_ram_inst (
        .axis_clk (axis_clk),
        .req      (tap_ram_req),
        .rdata    (tap_rdata)
    );

    // Sample history
    fir_bram data_ram_inst (
        .axis_clk (axis_clk),
        .req      (data_ram_req),
        .rdata    (data_rdata)
    );

endmodule

// ==== verilog/tap_arbiter.sv ====
module tap_arbiter (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  fir_pkg::ram_req_t  lite_req,
    input  logic               lite_valid,
    output logic               lite_gnt,
    output logic               lite_rvalid,
    input  fir_pkg::ram_req_t  eng_req,
    input  logic               eng_busy,
    output fir_pkg::ram_req_t  ram_req
);

    logic lite_owner;

    // Engine always has the port when busy
    assign lite_gnt = lite_valid && !eng_busy;

    always_comb begin
        if (eng_busy) begin
            ram_req = eng_req;
        end else if (lite_gnt) begin
            ram_req = lite_req;
        end else begin
            ram_req = '0;
        end
    end

    // Marks the next rdata word as belonging to the register side
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            lite_owner <= 1'b0;
        end else begin
            lite_owner <= lite_gnt && lite_req.en && !lite_req.we;
        end
    end

    assign lite_rvalid = lite_owner;

endmodule
